// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - logic/icache_pkg.sv
      - logic/icache_tag_array.sv
      - logic/icache_data_sram.sv
      - logic/icache_ctrl.sv
      - logic/icache_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/icache_asserts.sv
      - tests/icache_tb.sv

// File: icache.f
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_sram.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/tb_clk_gen.sv
tests/icache_asserts.sv
tests/icache_tb.sv

// File: logic/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::addr_t    addr,
	input  logic                 valid,
	input  logic                 flush,
	input  logic                 ready_ifid,
	input  icache_pkg::way_vec_t way_hit,
	input  icache_pkg::line_t    dout0,
	input  icache_pkg::line_t    dout1,
	input  icache_pkg::line_t    dout2,
	input  icache_pkg::line_t    dout3,
	input  icache_pkg::line_t    mem_line,
	output icache_pkg::addr_t    lookup_addr,
	output icache_pkg::way_vec_t victim,
	output logic                 fill,
	output icache_pkg::way_vec_t cen,
	output logic                 wen,
	output icache_pkg::inst_t    inst,
	output logic                 ready,
	output logic                 mem_req
);

	import icache_pkg::*;

	fetch_req_t req;      // Request accepted at the last advancing edge.
	way_vec_t   hit_q;    // Hit vector of that request.
	line_t      fill_q;   // Line forwarded on a miss.
	line_t      sel_line;
	way_vec_t   access;
	logic       miss;
	logic       advance;

	// A stalled stage keeps looking up its own held address.
	assign lookup_addr = ready_ifid ? addr : req.addr;

	assign miss    = valid && (way_hit == '0);
	assign mem_req = miss;
	assign fill    = miss && ready_ifid; // Nothing is written while stalled.
	assign advance = ready_ifid && !flush;

	// ****************************************
	// SRAM enables
	// ****************************************

	// Read the hit way, or write the victim way on a miss.
	assign access = miss ? victim : way_hit;
	assign cen    = ~(access & {NUM_WAYS{valid && ready_ifid}});
	assign wen    = ~fill;

	// ****************************************
	// Victim rotation and request stage
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_vec_t'(1); // Way 0 first.
		end else if (advance) begin
			victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			req   <= '0;
			hit_q <= '0;
		end else if (ready_ifid) begin
			if (flush) begin
				req.valid <= 1'b0; // Drop the output stage.
				hit_q     <= '0;
			end else begin
				req   <= '{addr: addr, valid: valid};
				hit_q <= way_hit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ready_ifid) begin
			fill_q <= mem_line;
		end
	end

	// ****************************************
	// Word select
	// ****************************************

	always_comb begin
		case (hit_q)
			4'b0001: sel_line = dout0;
			4'b0010: sel_line = dout1;
			4'b0100: sel_line = dout2;
			4'b1000: sel_line = dout3;
			default: sel_line = fill_q; // Miss, so the filled line is forwarded.
		endcase
	end

	assign inst  = sel_line[{req.addr[3:2], 5'd0} +: $bits(inst_t)];
	assign ready = req.valid;

endmodule

// File: logic/icache_data_sram.sv
`timescale 1ns/1ps

module icache_data_sram #(
	parameter int SETS = 64
) (
	input  logic                clk,
	input  logic                cen,   // Chip enable, active low.
	input  logic                wen,   // Write enable, active low.
	input  icache_pkg::index_t  index,
	input  icache_pkg::line_t   din,
	output icache_pkg::line_t   dout
);

	import icache_pkg::*;

	line_t mem [SETS]; // Behavioral stand-in for the macro array.

	// ****************************************
	// Single port access
	// ****************************************

	// One access per cycle: either a write or a read, never both.
	always_ff @(posedge clk) begin
		if (!cen) begin
			if (!wen) begin
				mem[index] <= din;   // Line fill from memory.
			end else begin
				dout <= mem[index];  // Read appears after the edge.
			end
		end
	end

	// With cen high the output latch holds its last value, as the macro does.
	// That keeps the read data stable across a downstream stall.

endmodule

// File: logic/icache_pkg.sv
package icache_pkg;

	localparam int NUM_WAYS = 4; // Victim rotation and way select are written for four ways.

	typedef logic [63:0] addr_t;            // Fetch byte address.
	typedef logic [31:0] inst_t;            // One instruction word.
	typedef logic [127:0] line_t;           // Four words per line.
	typedef logic [53:0] tag_t;             // Address bits 63 to 10.
	typedef logic [5:0] index_t;            // Address bits 9 to 4.
	typedef logic [NUM_WAYS-1:0] way_vec_t; // One bit per way.

	// Registered fetch request held by the control block.
	typedef struct packed {
		addr_t addr;
		logic  valid;
	} fetch_req_t;

	// ****************************************
	// Address field helpers
	// ****************************************

	function automatic tag_t tag_of(input addr_t a);
		return a[63:10];
	endfunction

	function automatic index_t index_of(input addr_t a);
		return a[9:4];
	endfunction

endpackage

// File: logic/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::addr_t    lookup_addr,
	input  icache_pkg::way_vec_t victim,
	input  logic                 fill,
	output icache_pkg::way_vec_t way_hit
);

	import icache_pkg::*;

	localparam int DEPTH = 1 << $bits(index_t); // One entry per set.

	tag_t             tags [NUM_WAYS][DEPTH];
	logic [DEPTH-1:0] vld  [NUM_WAYS];
	index_t           idx;
	tag_t             tag;

	assign idx = index_of(lookup_addr);
	assign tag = tag_of(lookup_addr);

	// ****************************************
	// Tag storage
	// ****************************************

	// The tag is written only into the way picked by the one-hot victim.
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill && victim[w]) begin
				tags[w][idx] <= tag;
			end
		end
	end

	// ****************************************
	// Valid bits
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				vld[w] <= '0; // Cache starts empty.
			end
		end else if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (victim[w]) begin
					vld[w][idx] <= 1'b1;
				end
			end
		end
	end

	// ****************************************
	// Parallel compare
	// ****************************************

	// All four ways are checked at once against the lookup tag.
	// A line that was never filled cannot hit, whatever its stale tag holds.
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
		assign way_hit[w] = vld[w][idx] && (tags[w][idx] == tag);
	end

endmodule

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
	parameter int SETS = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  icache_pkg::addr_t addr,
	input  logic              valid,
	input  logic              flush,
	input  logic              ready_ifid,
	output icache_pkg::inst_t inst,
	output logic              ready,
	output icache_pkg::addr_t mem_addr,
	output logic              mem_req,
	input  icache_pkg::line_t mem_line
);

	import icache_pkg::*;

	addr_t    lookup_addr;
	way_vec_t way_hit;
	way_vec_t victim;
	way_vec_t cen;
	logic     fill;
	logic     wen;
	index_t   index;
	line_t    dout [NUM_WAYS];

	assign index    = index_of(lookup_addr);
	assign mem_addr = lookup_addr; // Memory sees the same address as the lookup.

	icache_tag_array tag_i (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (lookup_addr),
		.victim      (victim),
		.fill        (fill),
		.way_hit     (way_hit)
	);

	// One data array per way; they share index, write enable and fill data.
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_data_sram #(
			.SETS (SETS)
		) sram_i (
			.clk   (clk),
			.cen   (cen[w]),
			.wen   (wen),
			.index (index),
			.din   (mem_line),
			.dout  (dout[w])
		);
	end

	icache_ctrl ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.valid       (valid),
		.flush       (flush),
		.ready_ifid  (ready_ifid),
		.way_hit     (way_hit),
		.dout0       (dout[0]),
		.dout1       (dout[1]),
		.dout2       (dout[2]),
		.dout3       (dout[3]),
		.mem_line    (mem_line),
		.lookup_addr (lookup_addr),
		.victim      (victim),
		.fill        (fill),
		.cen         (cen),
		.wen         (wen),
		.inst        (inst),
		.ready       (ready),
		.mem_req     (mem_req)
	);

endmodule

// File: tests/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts (
	input logic                 clk,
	input logic                 rst,
	input icache_pkg::addr_t    addr,
	input logic                 valid,
	input logic                 flush,
	input logic                 ready_ifid,
	input icache_pkg::inst_t    inst,
	input logic                 ready,
	input icache_pkg::line_t    mem_line,
	input icache_pkg::way_vec_t way_hit,
	input icache_pkg::way_vec_t victim
);

	import icache_pkg::*;

	int    errors = 0; // Failed assertions so far.
	inst_t line_word;

	// The backing memory answers every lookup address, so this is the word the fetch wants.
	assign line_word = mem_line[{addr[3:2], 5'd0} +: $bits(inst_t)];

	// ****************************************
	// Fetch response
	// ****************************************

	a_data: assert property (@(posedge clk) disable iff (rst)
		valid && ready_ifid && !flush |=> ready && inst == $past(line_word))
	else begin
		errors++;
		$error("Accepted fetch did not return its word on the next cycle");
	end

	a_flush: assert property (@(posedge clk) disable iff (rst)
		flush && ready_ifid |=> !ready)
	else begin
		errors++;
		$error("Output stage still valid after a flush");
	end

	// ****************************************
	// Stall and reset
	// ****************************************

	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		!ready_ifid && ready |=> ready && $stable(inst))
	else begin
		errors++;
		$error("Response changed while the fetch stage was stalled");
	end

	// A held lookup over a stall sees the same tags, since nothing is filled.
	a_stall_quiet: assert property (@(posedge clk) disable iff (rst)
		!ready_ifid ##1 !ready_ifid |-> $stable(way_hit))
	else begin
		errors++;
		$error("Tag array changed while the fetch stage was stalled");
	end

	a_reset: assert property (@(posedge clk)
		$fell(rst) |-> !ready && victim == way_vec_t'(1))
	else begin
		errors++;
		$error("Reset left ready set or the victim away from way 0");
	end

endmodule

bind icache_top icache_asserts asserts_i (.*);

// File: tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

	import icache_pkg::*;

	localparam int WAIT_LIMIT = 16; // Cycles allowed for any single wait.

	logic  clk;
	logic  rst;
	addr_t addr;
	logic  valid;
	logic  flush;
	logic  ready_ifid;
	inst_t inst;
	logic  ready;
	addr_t mem_addr;
	logic  mem_req;
	line_t mem_line;

	tag_t        ref_tag [NUM_WAYS][64];     // Reference tags per way and set.
	bit          ref_vld [NUM_WAYS][64];
	int          ref_victim = 0;              // Way the next fill goes to.
	addr_t       ref_held = '0;               // Address held in the request stage.
	logic        exp_ready = 1'b0;
	inst_t       exp_inst = '0;
	logic [31:0] rng = 32'ha783;
	int          errors = 0;

	tb_clk_gen clk_i (.clk(clk), .rst(rst));

	icache_top #(.SETS(64)) dut_i (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Every word of memory is a hash of its own word address.
	function automatic inst_t word_hash(input addr_t a);
		return xorshift32({a[31:2], 2'b01} ^ a[63:32] ^ 32'h5bd1_e995);
	endfunction

	// Eight tags over two sets, so the four ways keep getting evicted.
	function automatic addr_t conflict_addr(input logic [31:0] r);
		return 64'h0000_0040_0000_0000 | (64'(r[2:0]) << 10) | (64'(r[8]) << 4)
			| (64'(r[5:4]) << 2);
	endfunction

	function automatic int ref_way(input addr_t a);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_vld[w][a[9:4]] && ref_tag[w][a[9:4]] == a[63:10]) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Backing memory answers the line-fill port in the same cycle.
	always_comb begin
		for (int w = 0; w < 4; w++) begin
			mem_line[w*32 +: 32] = word_hash({mem_addr[63:4], 2'(w), 2'b00});
		end
	end

	task automatic check_value(input string name, input string what,
			input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
		end
	endtask

	// ****************************************
	// One clock of stimulus
	// ****************************************

	task automatic clock_cycle(input string name, input logic v, input addr_t a,
			input logic fl, input logic rdy);
		addr_t look;
		@(negedge clk);
		check_value(name, "ready", exp_ready, ready); // Result of the last edge.
		if (exp_ready) begin
			check_value(name, "inst", exp_inst, inst);
		end
		valid = v;
		addr = a;
		flush = fl;
		ready_ifid = rdy;
		look = rdy ? a : ref_held;
		#1;
		check_value(name, "mem_addr", look, mem_addr);
		check_value(name, "mem_req", v && ref_way(look) < 0, mem_req);
		if (rdy && v && ref_way(a) < 0) begin
			ref_tag[ref_victim][a[9:4]] = a[63:10]; // Fill at the coming edge.
			ref_vld[ref_victim][a[9:4]] = 1'b1;
		end
		if (rdy && !fl) begin
			ref_victim = (ref_victim + 1) % NUM_WAYS;
			ref_held = a;
			exp_ready = v;
			exp_inst = word_hash(a);
		end else if (rdy) begin
			exp_ready = 1'b0;
		end
	endtask

	task automatic wait_ready(input string name);
		int n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ready && n < WAIT_LIMIT);
		if (!ready) begin
			errors++;
			$display("%s: the cache gave no response within %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	task automatic fetch(input string name, input addr_t a);
		clock_cycle(name, 1'b1, a, 1'b0, 1'b1);
		wait_ready(name);
	endtask

	task automatic wait_reset();
		int n = 0;
		while (rst && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			errors++;
			$display("Reset was never released");
		end
	endtask

	initial begin
		logic [31:0] r;
		valid = 1'b0;
		addr = '0;
		flush = 1'b0;
		ready_ifid = 1'b0; // Stalled until the first stimulus cycle.
		wait_reset();
		fetch("miss_hit", 64'h0000_0000_0001_2344);
		fetch("miss_hit", 64'h0000_0000_0001_2344);
		for (int w = 0; w < 4; w++) begin
			fetch("word_sel", 64'h0000_0000_0000_5a00 + 64'(w * 4));
		end
		for (int k = 0; k < 15; k++) begin
			fetch("replace", 64'h0000_0000_0002_0070 + (64'(k % 5) << 10));
		end
		fetch("stall", 64'h0000_0000_0003_0104);
		for (int k = 0; k < 5; k++) begin
			clock_cycle("stall", 1'b1, 64'h0000_0000_0003_0208, 1'b0, 1'b0);
		end
		fetch("stall", 64'h0000_0000_0003_0208);
		fetch("flush", 64'h0000_0000_0004_4000);
		clock_cycle("flush", 1'b1, 64'h0000_0000_0004_4810, 1'b1, 1'b1);
		clock_cycle("flush", 1'b0, '0, 1'b0, 1'b1);
		fetch("flush", 64'h0000_0000_0004_4810);
		for (int k = 0; k < 2000; k++) begin
			r = next_rand();
			clock_cycle("random", r[0] | r[1], conflict_addr(next_rand()), r[7:4] == 4'd0,
				r[3:2] != 2'd0);
		end
		clock_cycle("final", 1'b0, '0, 1'b0, 1'b1);
		$display("Scoreboard errors: %0d, assertion errors: %0d", errors,
			dut_i.asserts_i.errors);
		if (errors == 0 && dut_i.asserts_i.errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // Released away from the sampling edge.
	end

endmodule
